//--- all.f
+incdir+.
sched_pkg.sv
time_base.sv
cmd_fifo.sv
cmd_scheduler.sv
chip_regs.sv
readback_collector.sv
sched_top.sv
tb_sched_top.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_sched_top -f all.f -o sim_tb \
	&& ./obj_dir/sim_tb \
	|| exit 1

//--- tb_sched_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sched_defs.svh"

module tb_sched_top import sched_pkg::*; ();

	localparam int NUM_CMDS   = 8;
	localparam int WAIT_LIMIT = 100; // cycles allowed per bus write
	localparam int IDLE_SPAN  = 20;

	typedef struct packed {
		time_t      stamp;
		logic [3:0] chip;
		logic [1:0] reg_idx;
		logic       use_lfsr; // data from lfsr instead of fixed
		bus_data_t  fixed;
	} stim_t;

	logic       clk;
	logic       rst;
	logic       start;
	logic       push;
	sched_cmd_t push_cmd;
	logic [3:0] rd_chip;
	logic [1:0] rd_reg;
	time_t      cur_time;
	bus_wr_t    bus;
	bus_data_t  rd_data;
	logic       full;
	logic       empty;

	stim_t      stim [NUM_CMDS];
	sched_cmd_t cmds [NUM_CMDS];
	bus_data_t  exp_regs [`SCHED_NUM_CHIPS][4]; // reference register model
	logic [31:0] lfsr_state;

	sched_top u_sched_top (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.push     (push),
		.push_cmd (push_cmd),
		.rd_chip  (rd_chip),
		.rd_reg   (rd_reg),
		.cur_time (cur_time),
		.bus      (bus),
		.rd_data  (rd_data),
		.full     (full),
		.empty    (empty)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_word(output bus_data_t w);
		int k;
		w = '0;
		for (k = 0; k < 32; k++) begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	task automatic fill_table();
		stim[0] = '{stamp: 32'd0,  chip: 4'd0, reg_idx: 2'd0, use_lfsr: 1'b0, fixed: 32'h1111_0000};
		stim[1] = '{stamp: 32'd2,  chip: 4'd1, reg_idx: 2'd1, use_lfsr: 1'b1, fixed: 32'h0};
		stim[2] = '{stamp: 32'd10, chip: 4'd2, reg_idx: 2'd2, use_lfsr: 1'b0, fixed: 32'h2222_0202};
		stim[3] = '{stamp: 32'd40, chip: 4'd3, reg_idx: 2'd3, use_lfsr: 1'b1, fixed: 32'h0};
		// chip 5 has no bank
		stim[4] = '{stamp: 32'd0,  chip: 4'd5, reg_idx: 2'd2, use_lfsr: 1'b0, fixed: 32'hdead_beef};
		stim[5] = '{stamp: 32'd46, chip: 4'd0, reg_idx: 2'd3, use_lfsr: 1'b1, fixed: 32'h0};
		stim[6] = '{stamp: 32'd60, chip: 4'd1, reg_idx: 2'd1, use_lfsr: 1'b0, fixed: 32'hcafe_0001};
		stim[7] = '{stamp: 32'd0,  chip: 4'd2, reg_idx: 2'd0, use_lfsr: 1'b1, fixed: 32'h0};
	endtask

	// commands plus the register contents they should leave behind
	task automatic build_commands();
		int i;
		int r;
		bus_data_t d;
		bus_addr_t a;
		for (i = 0; i < `SCHED_NUM_CHIPS; i++) begin
			for (r = 0; r < 4; r++) begin
				exp_regs[i][r] = '0;
			end
		end
		for (i = 0; i < NUM_CMDS; i++) begin
			if (stim[i].use_lfsr) begin
				random_word(d);
			end else begin
				d = stim[i].fixed;
			end
			a = {stim[i].chip, 10'(i), stim[i].reg_idx}; // middle bits are don't-care
			cmds[i] = '{stamp: stim[i].stamp, data: d, addr: a};
			if (stim[i].chip < `SCHED_NUM_CHIPS) begin
				exp_regs[stim[i].chip][stim[i].reg_idx] = d;
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic wait_bus_write(input int idx);
		int n;
		n = 0;
		@(negedge clk);
		while (bus.wr !== 1'b1) begin
			if (n >= WAIT_LIMIT) begin
				abort_run($sformatf("timed out waiting for bus write %0d", idx));
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	task automatic idle_window(input logic time_frozen);
		repeat (IDLE_SPAN) begin
			@(negedge clk);
			check_value("bus.wr", 32'd0, bus.wr);
			if (time_frozen) begin
				check_value("cur_time", 32'd0, cur_time);
			end
		end
	endtask

	task automatic read_reg(input int c, input int r, input bus_data_t expected);
		@(posedge clk);
		rd_chip <= 4'(c);
		rd_reg  <= 2'(r);
		@(posedge clk); // collector registers the select here
		@(negedge clk);
		check_value($sformatf("rd_data chip %0d reg %0d", c, r), expected, rd_data);
	endtask

	initial begin
		int i;
		int c;
		int r;
		time_t prev_time;
		rst        = 1'b1;
		start      = 1'b0;
		push       = 1'b0;
		push_cmd   = '0;
		rd_chip    = '0;
		rd_reg     = '0;
		lfsr_state = 32'd32;
		fill_table();
		build_commands();
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (i = 0; i < NUM_CMDS; i++) begin
			@(posedge clk);
			push     <= 1'b1;
			push_cmd <= cmds[i];
		end
		@(posedge clk);
		push <= 1'b0;
		@(negedge clk);
		check_value("full", 32'd1, full);
		check_value("empty", 32'd0, empty);
		idle_window(1'b1); // time base still stopped

		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;

		prev_time = '0;
		for (i = 0; i < NUM_CMDS; i++) begin
			wait_bus_write(i);
			check_value($sformatf("bus.addr write %0d", i), 32'(cmds[i].addr), 32'(bus.addr));
			check_value($sformatf("bus.data write %0d", i), cmds[i].data, bus.data);
			if (cmds[i].stamp != '0) begin
				check_value($sformatf("cur_time >= stamp write %0d", i), 32'd1,
					32'(cur_time >= cmds[i].stamp));
				// far-off stamp goes out on the exact tick
				if (cmds[i].stamp > prev_time + 3) begin
					check_value($sformatf("cur_time write %0d", i), cmds[i].stamp, cur_time);
				end
			end
			prev_time = cur_time;
		end

		check_value("empty", 32'd1, empty);
		idle_window(1'b0);

		for (c = 0; c < `SCHED_NUM_CHIPS; c++) begin
			for (r = 0; r < 4; r++) begin
				read_reg(c, r, exp_regs[c][r]);
			end
		end
		for (r = 0; r < 4; r++) begin
			read_reg(5, r, '0); // unmapped chip reads zero
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sched_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sched_defs.svh"

module sched_top import sched_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       push,
	input  sched_cmd_t push_cmd,
	input  logic [`SCHED_CHIP_HI-`SCHED_CHIP_LO:0] rd_chip,
	input  logic [`SCHED_REG_HI-`SCHED_REG_LO:0]   rd_reg,
	output time_t      cur_time,
	output bus_wr_t    bus,
	output bus_data_t  rd_data,
	output logic       full,
	output logic       empty
);

	sched_cmd_t fifo_cmd;
	logic fifo_valid;
	logic fifo_rd;
	bus_data_t [`SCHED_NUM_CHIPS-1:0][3:0] chip_regs_all;

	time_base u_time_base (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.cur_time (cur_time)
	);

	cmd_fifo #(.DEPTH(`SCHED_FIFO_DEPTH)) u_cmd_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (push),
		.din   (push_cmd),
		.rd    (fifo_rd),
		.dout  (fifo_cmd),
		.valid (fifo_valid),
		.empty (empty),
		.full  (full)
	);

	cmd_scheduler u_cmd_scheduler (
		.clk        (clk),
		.rst        (rst),
		.cur_time   (cur_time),
		.fifo_cmd   (fifo_cmd),
		.fifo_valid (fifo_valid),
		.empty      (empty),
		.fifo_rd    (fifo_rd),
		.bus        (bus)
	);

	// one register bank per chip on the shared bus
	for (genvar g = 0; g < `SCHED_NUM_CHIPS; g++) begin : g_chip
		chip_regs #(.CHIP_ID(g)) u_chip_regs (
			.clk  (clk),
			.rst  (rst),
			.bus  (bus),
			.regs (chip_regs_all[g])
		);
	end

	readback_collector u_readback_collector (
		.clk           (clk),
		.rst           (rst),
		.chip_regs_all (chip_regs_all),
		.rd_chip       (rd_chip),
		.rd_reg        (rd_reg),
		.rd_data       (rd_data)
	);

endmodule

`default_nettype wire

//--- readback_collector.sv
`timescale 1ns/1ns
`default_nettype none

`include "sched_defs.svh"

module readback_collector import sched_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  bus_data_t [`SCHED_NUM_CHIPS-1:0][3:0] chip_regs_all,
	input  logic [`SCHED_CHIP_HI-`SCHED_CHIP_LO:0] rd_chip,
	input  logic [`SCHED_REG_HI-`SCHED_REG_LO:0]   rd_reg,
	output bus_data_t rd_data
);

	bus_data_t [3:0] chip_sel; // bank picked by rd_chip
	bus_data_t       word_sel;

	always_comb begin
		chip_sel = '0;
		if (rd_chip < `SCHED_NUM_CHIPS) begin
			chip_sel = chip_regs_all[rd_chip];
		end
		word_sel = chip_sel[rd_reg];
	end

	// one cycle from select to data
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			rd_data <= word_sel;
		end
	end

endmodule

`default_nettype wire

//--- chip_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "sched_defs.svh"

module chip_regs import sched_pkg::*; #(
	parameter int CHIP_ID = 0
) (
	input  logic            clk,
	input  logic            rst,
	input  bus_wr_t         bus,
	output bus_data_t [3:0] regs
);

	localparam int CHIP_W = `SCHED_CHIP_HI - `SCHED_CHIP_LO + 1;
	localparam int REG_W  = `SCHED_REG_HI - `SCHED_REG_LO + 1;
	localparam logic [CHIP_W-1:0] MY_CHIP = CHIP_W'(CHIP_ID);

	logic [CHIP_W-1:0] chip_field;
	logic [REG_W-1:0]  reg_idx;
	logic hit;

	assign chip_field = bus.addr[`SCHED_CHIP_HI:`SCHED_CHIP_LO];
	assign reg_idx    = bus.addr[`SCHED_REG_HI:`SCHED_REG_LO];

	// write strobe addressed to this bank
	assign hit = bus.wr && (chip_field == MY_CHIP);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs <= '0;
		end else if (hit) begin
			regs[reg_idx] <= bus.data;
		end
	end

endmodule

`default_nettype wire

//--- cmd_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_scheduler import sched_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  time_t      cur_time,
	input  sched_cmd_t fifo_cmd,
	input  logic       fifo_valid,
	input  logic       empty,
	output logic       fifo_rd,
	output bus_wr_t    bus
);

	sched_state_e state;
	sched_state_e next_state;
	sched_cmd_t   cmd;
	logic load_cmd;
	logic issue;
	logic due;

	// stamp of zero goes out immediately
	assign due = (cmd.stamp == '0) || (cur_time >= cmd.stamp);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		fifo_rd    = 1'b0;
		load_cmd   = 1'b0;
		issue      = 1'b0;
		case (state)
			st_idle: begin
				if (cur_time != '0) begin // time base running
					next_state = st_fetch;
				end
			end
			st_fetch: begin
				if (!empty) begin
					fifo_rd    = 1'b1;
					next_state = st_fifo_wait;
				end
			end
			st_fifo_wait: begin
				load_cmd   = 1'b1; // fifo output lands this cycle
				next_state = st_exec;
			end
			st_exec: begin
				if (due) begin
					issue      = 1'b1;
					next_state = st_fetch;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	// command register is cleared once the write has gone out
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmd <= '0;
		end else if (issue) begin
			cmd <= '0;
		end else if (load_cmd) begin
			cmd <= fifo_cmd;
		end
	end

	assign bus.wr   = issue;
	assign bus.addr = cmd.addr;
	assign bus.data = cmd.data;

	// fifo must answer the pop exactly one cycle later
	a_valid_in_wait: assert property (@(posedge clk) disable iff (rst)
		state == st_fifo_wait |-> fifo_valid)
		else $error("cmd_scheduler: no fifo data in fifo_wait");

endmodule

`default_nettype wire

//--- cmd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "sched_defs.svh"

module cmd_fifo import sched_pkg::*; #(
	parameter int DEPTH = `SCHED_FIFO_DEPTH
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  sched_cmd_t din,
	input  logic       rd,
	output sched_cmd_t dout,
	output logic       valid,
	output logic       empty,
	output logic       full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	sched_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = push && !full;
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
		if (do_rd) begin
			dout <= mem[rd_ptr]; // head entry held until next pop
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_rd; // one cycle pulse
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("cmd_fifo: push while full");
	a_no_rd_empty: assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
		else $error("cmd_fifo: read while empty");

endmodule

`default_nettype wire

//--- time_base.sv
`timescale 1ns/1ns
`default_nettype none

module time_base import sched_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	output time_t cur_time
);

	logic running;

	// latched on the start pulse, stays set until reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running <= 1'b0;
		end else if (start) begin
			running <= 1'b1;
		end
	end

	// first increment happens on the edge that samples start
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cur_time <= '0;
		end else if (start || running) begin
			cur_time <= cur_time + 1'b1; // no rollover handling
		end
	end

endmodule

`default_nettype wire

//--- sched_pkg.sv
`default_nettype none

`include "sched_defs.svh"

package sched_pkg;

	typedef logic [`SCHED_TIME_W-1:0] time_t;
	typedef logic [`SCHED_ADDR_W-1:0] bus_addr_t;
	typedef logic [`SCHED_DATA_W-1:0] bus_data_t;

	// stamp in the top bits, address at the bottom
	typedef struct packed {
		time_t     stamp; // 0 = issue at once
		bus_data_t data;
		bus_addr_t addr;
	} sched_cmd_t;

	typedef struct packed {
		logic      wr;
		bus_addr_t addr;
		bus_data_t data;
	} bus_wr_t;

	typedef enum logic [3:0] {
		st_idle      = 4'b0100,
		st_fetch     = 4'b0000,
		st_fifo_wait = 4'b0001,
		st_exec      = 4'b0010
	} sched_state_e;

endpackage

`default_nettype wire

//--- sched_defs.svh
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// command and bus widths
`define SCHED_TIME_W      32
`define SCHED_DATA_W      32
`define SCHED_ADDR_W      16

`define SCHED_NUM_CHIPS   4
`define SCHED_FIFO_DEPTH  8

// address fields with bits 11..2 unused
`define SCHED_CHIP_HI     15
`define SCHED_CHIP_LO     12
`define SCHED_REG_HI      1
`define SCHED_REG_LO      0

`endif
